// ==== verilog/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

`define CPU_XLEN      32
`define CPU_MASK_W    4

////////////////////////////////////////
// Memory
////////////////////////////////////////

`define CPU_MEM_WORDS 256
`define CPU_WORD_AW   $clog2(`CPU_MEM_WORDS)  // Word address bits, byte address >> 2
`define CPU_SRAM_LAT  2

// First instruction fetched after run goes high
`define CPU_RESET_PC  32'h0000_0000

`endif

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP_REG = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        CORE_IDLE, CORE_FETCH, CORE_EXEC, CORE_MEM, CORE_HALT
    } core_state_e;

    typedef enum logic [1:0] {
        CTRL_IDLE, CTRL_READ, CTRL_WRITE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        HALT_NONE     = 2'd0,
        HALT_EBREAK   = 2'd1,
        HALT_ILLEGAL  = 2'd2,
        HALT_MISALIGN = 2'd3
    } halt_cause_e;

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [4:0]           rs1_addr,
    input  logic [4:0]           rs2_addr,
    output logic [`CPU_XLEN-1:0] rs1_data,
    output logic [`CPU_XLEN-1:0] rs2_data,
    input  logic [4:0]           rd_addr,
    input  logic [`CPU_XLEN-1:0] rd_data,
    input  logic                 rd_we,
    output logic [`CPU_XLEN-1:0] a0
);

    logic [`CPU_XLEN-1:0] regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign a0 = regs[10];

endmodule

// ==== verilog/core.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    output logic [`CPU_XLEN-1:0]  ifetch_addr,
    output logic                  ifetch_req,
    input  logic [`CPU_XLEN-1:0]  ifetch_data,
    input  logic                  ifetch_done,
    output logic [`CPU_XLEN-1:0]  data_addr,
    output logic [`CPU_XLEN-1:0]  data_wdata,
    output logic                  data_size,    // 1 for word, 0 for byte
    output logic                  data_rd,
    output logic                  data_wr,
    input  logic [`CPU_XLEN-1:0]  data_rdata,
    input  logic                  data_done,
    output logic                  halted,
    output cpu_pkg::halt_cause_e  halt_cause,
    output logic [`CPU_XLEN-1:0]  halt_pc,
    output logic [`CPU_XLEN-1:0]  a0
);

    cpu_pkg::core_state_e state;
    cpu_pkg::opcode_e     opcode;
    cpu_pkg::halt_cause_e cause;
    logic [`CPU_XLEN-1:0] pc, instr, next_pc, alu_res, mem_addr, rs1_data, rs2_data;
    logic [`CPU_XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 wb_en, is_load, is_store;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};

    assign mem_addr = rs1_data + ((opcode == cpu_pkg::OPC_STORE) ? imm_s : imm_i);

    always_comb begin
        alu_res  = '0;
        wb_en    = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        next_pc  = pc + 32'd4;
        cause    = cpu_pkg::HALT_NONE;
        case (opcode)
            cpu_pkg::OPC_LUI: begin
                alu_res = imm_u;
                wb_en   = 1'b1;
            end
            cpu_pkg::OPC_OP_IMM: begin
                alu_res = rs1_data + imm_i;
                wb_en   = (funct3 == 3'b000);
                if (funct3 != 3'b000) cause = cpu_pkg::HALT_ILLEGAL;
            end
            cpu_pkg::OPC_OP_REG: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    alu_res = rs1_data + rs2_data;
                    wb_en   = 1'b1;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    alu_res = rs1_data - rs2_data;
                    wb_en   = 1'b1;
                end else begin
                    cause = cpu_pkg::HALT_ILLEGAL;
                end
            end
            cpu_pkg::OPC_LOAD: begin
                is_load = (funct3 == 3'b010);    // LW only
                if (!is_load) cause = cpu_pkg::HALT_ILLEGAL;
                else if (mem_addr[1:0] != 2'b00) cause = cpu_pkg::HALT_MISALIGN;
            end
            cpu_pkg::OPC_STORE: begin
                is_store = (funct3 == 3'b010) || (funct3 == 3'b000);
                if (!is_store) cause = cpu_pkg::HALT_ILLEGAL;
                else if (funct3 == 3'b010 && mem_addr[1:0] != 2'b00) cause = cpu_pkg::HALT_MISALIGN;
            end
            cpu_pkg::OPC_BRANCH: begin
                if (funct3 != 3'b001) cause = cpu_pkg::HALT_ILLEGAL;
                else if (rs1_data != rs2_data) next_pc = pc + imm_b;
            end
            cpu_pkg::OPC_SYSTEM: begin
                cause = (instr == 32'h0010_0073) ? cpu_pkg::HALT_EBREAK : cpu_pkg::HALT_ILLEGAL;
            end
            default: cause = cpu_pkg::HALT_ILLEGAL;
        endcase
    end

    regfile i_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_addr(instr[19:15]),
        .rs2_addr(instr[24:20]),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_addr (instr[11:7]),
        .rd_data (state == cpu_pkg::CORE_MEM ? data_rdata : alu_res),
        .rd_we   ((state == cpu_pkg::CORE_EXEC && wb_en) ||
                  (state == cpu_pkg::CORE_MEM && data_done && is_load)),
        .a0      (a0)
    );

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    assign ifetch_addr = pc;
    assign data_addr   = mem_addr;   // Instruction and registers hold steady through MEM
    assign data_wdata  = rs2_data;
    assign data_size   = (funct3 == 3'b010);

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::CORE_FETCH && ifetch_done) instr <= ifetch_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= cpu_pkg::CORE_IDLE;
            pc         <= `CPU_RESET_PC;
            ifetch_req <= 1'b0;
            data_rd    <= 1'b0;
            data_wr    <= 1'b0;
            halted     <= 1'b0;
            halt_cause <= cpu_pkg::HALT_NONE;
            halt_pc    <= '0;
        end else begin
            ifetch_req <= 1'b0;
            data_rd    <= 1'b0;
            data_wr    <= 1'b0;
            case (state)
                cpu_pkg::CORE_IDLE: if (run) begin
                    state      <= cpu_pkg::CORE_FETCH;
                    pc         <= `CPU_RESET_PC;
                    ifetch_req <= 1'b1;
                end
                cpu_pkg::CORE_FETCH: if (ifetch_done) state <= cpu_pkg::CORE_EXEC;
                cpu_pkg::CORE_EXEC: begin
                    if (cause != cpu_pkg::HALT_NONE) begin
                        state      <= cpu_pkg::CORE_HALT;
                        halted     <= 1'b1;
                        halt_cause <= cause;
                        halt_pc    <= pc;
                    end else if (is_load || is_store) begin
                        state   <= cpu_pkg::CORE_MEM;
                        data_rd <= is_load;
                        data_wr <= is_store;
                    end else begin
                        state      <= cpu_pkg::CORE_FETCH;
                        pc         <= next_pc;
                        ifetch_req <= 1'b1;
                    end
                end
                cpu_pkg::CORE_MEM: if (data_done) begin
                    state      <= cpu_pkg::CORE_FETCH;
                    pc         <= pc + 32'd4;
                    ifetch_req <= 1'b1;
                end
                default: state <= cpu_pkg::CORE_HALT;  // Stays here until reset
            endcase
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(data_rd && data_wr));

endmodule

// ==== verilog/mem_ctrl.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module mem_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  logic [`CPU_XLEN-1:0]    ifetch_addr,
    input  logic                    ifetch_req,
    output logic [`CPU_XLEN-1:0]    ifetch_data,
    output logic                    ifetch_done,
    input  logic [`CPU_XLEN-1:0]    data_addr,
    input  logic [`CPU_XLEN-1:0]    data_wdata,
    input  logic                    data_size,
    input  logic                    data_rd,
    input  logic                    data_wr,
    output logic [`CPU_XLEN-1:0]    data_rdata,
    output logic                    data_done,
    input  logic                    load_en,
    input  logic [`CPU_XLEN-1:0]    load_addr,
    input  logic [`CPU_XLEN-1:0]    load_data,
    output logic [`CPU_WORD_AW-1:0] raddr,
    output logic                    raddr_valid,
    output logic                    rready,
    input  logic [`CPU_XLEN-1:0]    rdata,
    input  logic                    rvalid,
    output logic [`CPU_WORD_AW-1:0] waddr,
    output logic [`CPU_XLEN-1:0]    wdata,
    output logic [`CPU_MASK_W-1:0]  wmask,
    output logic                    wen
);

    cpu_pkg::ctrl_state_e state;
    logic                 req_is_data;  // Who gets the read data back
    logic                 fetch_acc, data_acc;

    assign fetch_acc   = (state == cpu_pkg::CTRL_IDLE) && ifetch_req;
    assign data_acc    = (state == cpu_pkg::CTRL_IDLE) && (data_rd || data_wr);
    assign raddr_valid = fetch_acc || (data_acc && data_rd);
    assign raddr       = fetch_acc ? ifetch_addr[2 +: `CPU_WORD_AW] : data_addr[2 +: `CPU_WORD_AW];
    assign rready      = (state == cpu_pkg::CTRL_READ);

    // Load port owns the write channel while the core is stopped
    always_comb begin
        waddr = run ? data_addr[2 +: `CPU_WORD_AW] : load_addr[2 +: `CPU_WORD_AW];
        wdata = run ? data_wdata : load_data;
        wmask = '1;
        wen   = run ? (data_acc && data_wr) : load_en;
        if (run && !data_size) begin
            wdata = {(`CPU_MASK_W){data_wdata[7:0]}};   // Same byte on every lane
            wmask = `CPU_MASK_W'(1) << data_addr[1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= cpu_pkg::CTRL_IDLE;
            req_is_data <= 1'b0;
            ifetch_done <= 1'b0;
            data_done   <= 1'b0;
        end else begin
            ifetch_done <= 1'b0;
            data_done   <= 1'b0;
            case (state)
                cpu_pkg::CTRL_IDLE: if (raddr_valid) begin
                    state       <= cpu_pkg::CTRL_READ;
                    req_is_data <= !fetch_acc;
                end else if (data_acc) begin
                    state     <= cpu_pkg::CTRL_WRITE;
                    data_done <= 1'b1;   // Store already landed this edge
                end
                cpu_pkg::CTRL_READ: if (rvalid) begin
                    state       <= cpu_pkg::CTRL_IDLE;
                    data_done   <= req_is_data;
                    ifetch_done <= !req_is_data;
                end
                default: state <= cpu_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::CTRL_READ && rvalid) begin
            if (req_is_data) data_rdata <= rdata;
            else ifetch_data <= rdata;
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!arst_n) !(fetch_acc && data_acc));

endmodule

// ==== verilog/sram.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module sram (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CPU_WORD_AW-1:0] raddr,
    input  logic                    raddr_valid,
    output logic [`CPU_XLEN-1:0]    rdata,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic [`CPU_WORD_AW-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]    wdata,
    input  logic [`CPU_MASK_W-1:0]  wmask,
    input  logic                    wen
);

    logic [`CPU_XLEN-1:0]     mem [`CPU_MEM_WORDS];
    logic [`CPU_XLEN-1:0]     rd_pipe [`CPU_SRAM_LAT];
    logic [`CPU_SRAM_LAT-1:0] vld;
    logic [`CPU_SRAM_LAT-1:0] stage_rdy;

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < `CPU_MASK_W; b++) begin
                if (wmask[b]) mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Read pipeline
    ////////////////////////////////////////

    // A stage moves when it is empty or the stage after it moves
    always_comb begin
        stage_rdy[`CPU_SRAM_LAT-1] = !vld[`CPU_SRAM_LAT-1] || rready;
        for (int i = `CPU_SRAM_LAT-2; i >= 0; i--) begin
            stage_rdy[i] = !vld[i] || stage_rdy[i+1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld <= '0;
        end else begin
            if (stage_rdy[0]) vld[0] <= raddr_valid;
            for (int i = 1; i < `CPU_SRAM_LAT; i++) begin
                if (stage_rdy[i]) vld[i] <= vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_rdy[0]) rd_pipe[0] <= mem[raddr];
        for (int i = 1; i < `CPU_SRAM_LAT; i++) begin
            if (stage_rdy[i]) rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rvalid = vld[`CPU_SRAM_LAT-1];
    assign rdata  = rd_pipe[`CPU_SRAM_LAT-1];

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 load_en,
    input  logic [`CPU_XLEN-1:0] load_addr,   // Byte address, word aligned
    input  logic [`CPU_XLEN-1:0] load_data,
    output logic                 halted,
    output cpu_pkg::halt_cause_e halt_cause,
    output logic [`CPU_XLEN-1:0] halt_pc,
    output logic [`CPU_XLEN-1:0] a0
);

    // Core side
    logic [`CPU_XLEN-1:0]    ifetch_addr, ifetch_data;
    logic                    ifetch_req, ifetch_done;
    logic [`CPU_XLEN-1:0]    data_addr, data_wdata, data_rdata;
    logic                    data_size, data_rd, data_wr, data_done;

    // SRAM side
    logic [`CPU_WORD_AW-1:0] raddr, waddr;
    logic                    raddr_valid, rready, rvalid, wen;
    logic [`CPU_XLEN-1:0]    rdata, wdata;
    logic [`CPU_MASK_W-1:0]  wmask;

    core i_core (.*);

    mem_ctrl i_mem_ctrl (.*);

    sram i_sram (.*);

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_tb;

    localparam int NUM_TESTS = 6;
    localparam int MAX_WORDS = 16;
    localparam int TIMEOUT   = 2000;

    logic                 clk, arst_n, run, load_en;
    logic [`CPU_XLEN-1:0] load_addr, load_data, halt_pc, a0;
    logic                 halted;
    cpu_pkg::halt_cause_e halt_cause;

    // Test table, filled at time zero because some programs carry random data
    string                test_name [NUM_TESTS];
    logic [`CPU_XLEN-1:0] prog_mem  [NUM_TESTS][MAX_WORDS];
    int                   prog_len  [NUM_TESTS];
    cpu_pkg::halt_cause_e exp_cause [NUM_TESTS];
    logic [`CPU_XLEN-1:0] exp_pc    [NUM_TESTS];
    logic [`CPU_XLEN-1:0] exp_a0    [NUM_TESTS];

    cpu i_cpu (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // RV32 instruction encoders
    ////////////////////////////////////////

    function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add_sub(logic sub, logic [4:0] rd, logic [4:0] rs1,
                                            logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    // Word store when word is set, byte store otherwise
    function automatic logic [31:0] store(logic word, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 1'b0, word, 1'b0, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bne(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(int t, logic [31:0] word);
        prog_mem[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    // LUI plus ADDI, with the upper part rounded for the sign-extended low part
    task automatic emit_const(int t, logic [4:0] rd, logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit(t, lui(rd, upper[19:0]));
        emit(t, addi(rd, rd, value[11:0]));
    endtask

    task automatic build_tests();
        logic [31:0] word_a, word_b, merged;
        logic [7:0]  byte_val;
        int          sum;
        word_a   = $urandom;
        word_b   = $urandom;
        byte_val = $urandom;
        for (int t = 0; t < NUM_TESTS; t++) prog_len[t] = 0;

        test_name[0] = "arith";
        emit(0, lui(10, 20'h12345));
        emit(0, addi(11, 0, 12'd100));
        emit(0, addi(12, 0, 12'hFF9));             // -7
        emit(0, add_sub(0, 13, 11, 12));
        emit(0, add_sub(0, 10, 10, 13));
        emit(0, add_sub(1, 10, 10, 11));
        emit(0, 32'h0010_0073);
        exp_cause[0] = cpu_pkg::HALT_EBREAK;
        exp_pc[0]    = 32'd24;
        exp_a0[0]    = 32'h1234_5000 + (32'd100 + 32'hFFFF_FFF9) - 32'd100;

        test_name[1] = "word_mem";
        emit_const(1, 5, word_a);
        emit(1, store(1, 5, 0, 12'h080));
        emit(1, lw(10, 0, 12'h080));
        emit(1, 32'h0010_0073);
        exp_cause[1] = cpu_pkg::HALT_EBREAK;
        exp_pc[1]    = 32'd16;
        exp_a0[1]    = word_a;

        test_name[2] = "byte_mask";
        emit_const(2, 5, word_b);
        emit(2, store(1, 5, 0, 12'h090));
        emit(2, addi(6, 0, {4'h0, byte_val}));
        emit(2, store(0, 6, 0, 12'h092));           // Lane 2
        emit(2, lw(10, 0, 12'h090));
        emit(2, 32'h0010_0073);
        merged        = word_b;
        merged[23:16] = byte_val;
        exp_cause[2]  = cpu_pkg::HALT_EBREAK;
        exp_pc[2]     = 32'd24;
        exp_a0[2]     = merged;

        test_name[3] = "branch";
        emit(3, addi(5, 0, 12'd7));
        emit(3, addi(10, 0, 12'd0));
        emit(3, add_sub(0, 10, 10, 5));
        emit(3, addi(5, 5, 12'hFFF));
        emit(3, bne(5, 0, 13'h1FF8));              // Back two instructions
        emit(3, 32'h0010_0073);
        sum = 0;
        for (int n = 7; n != 0; n--) sum += n;
        exp_cause[3] = cpu_pkg::HALT_EBREAK;
        exp_pc[3]    = 32'd20;
        exp_a0[3]    = sum;

        test_name[4] = "illegal";
        emit(4, addi(10, 0, 12'd5));
        emit(4, 32'h0000_0000);
        exp_cause[4] = cpu_pkg::HALT_ILLEGAL;
        exp_pc[4]    = 32'd4;
        exp_a0[4]    = 32'd5;

        test_name[5] = "misalign";
        emit(5, addi(10, 0, 12'd42));
        emit(5, addi(6, 0, 12'h080));
        emit(5, lw(10, 6, 12'd2));
        emit(5, 32'h0010_0073);
        exp_cause[5] = cpu_pkg::HALT_MISALIGN;
        exp_pc[5]    = 32'd8;
        exp_a0[5]    = 32'd42;
    endtask

    ////////////////////////////////////////
    // Sequencing and checks
    ////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        #1 arst_n = 1'b0;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge clk);
            #1 load_en = 1'b1;
            load_addr = i * 4;
            load_data = prog_mem[t][i];
        end
        @(posedge clk);
        #1 load_en = 1'b0;
        run = 1'b1;                                 // Last word landed at this edge
    endtask

    task automatic wait_halted(int t);
        int cycles;
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("TIMEOUT: test %s did not halt within %0d cycles", test_name[t], TIMEOUT);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_word(string name, string what, logic [`CPU_XLEN-1:0] expected,
                              logic [`CPU_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED test %s %s: expected %h actual %h",
                     name, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_cause(string name, cpu_pkg::halt_cause_e expected,
                               cpu_pkg::halt_cause_e actual);
        if (actual !== expected) begin
            $display("CHECK FAILED test %s halt_cause: expected %s actual %s",
                     name, expected.name(), actual.name());
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'h267c99f1));
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            apply_reset();
            load_program(t);
            wait_halted(t);
            check_cause(test_name[t], exp_cause[t], halt_cause);
            check_word(test_name[t], "halt_pc", exp_pc[t], halt_pc);
            check_word(test_name[t], "a0", exp_a0[t], a0);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/core.sv
verilog/mem_ctrl.sv
verilog/sram.sv
verilog/cpu.sv
verification/cpu_tb.sv
